/* design/csr_soc_pkg.sv */
// CSR subsystem widths, register map, control bits and bus types
package csr_soc_pkg;

	// --------------------
	// bus geometry
	// --------------------
	// word address, bank select sits in the top bits
	localparam int CSR_ADDR_W = 14;
	localparam int CSR_DATA_W = 32;
	localparam int BANK_W = 4;

	// timers fill banks 0..3, everything above reads zero
	localparam int NUM_TIMERS = 4;

	// --------------------
	// reset stretch
	// --------------------
	// hold time after the trigger drops
	localparam int RST_HOLD_CYCLES = 16;
	localparam int RST_CNT_W = $clog2(RST_HOLD_CYCLES + 1);

	// --------------------
	// timer register map
	// --------------------
	// offset lives in the two lowest address bits
	localparam logic [1:0] REG_CTRL = 2'd0;
	localparam logic [1:0] REG_COMPARE = 2'd1;
	localparam logic [1:0] REG_COUNT = 2'd2;
	localparam logic [1:0] REG_STATUS = 2'd3;

	// control register layout
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_IRQEN_BIT = 1;
	localparam int CTRL_RELOAD_BIT = 2;
	localparam int CTRL_W = 3;

	// shared bus types
	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [CSR_DATA_W-1:0] csr_data_t;
	typedef logic [BANK_W-1:0] bank_t;

endpackage

/* design/reset_debounce.sv */
// retriggerable reset stretcher driving the held system reset
`timescale 1ns/1ps

module reset_debounce import csr_soc_pkg::*; (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o
);

	// cycles left before release
	logic [RST_CNT_W-1:0] hold_cnt;

	// --------------------
	// hold counter
	// --------------------
	// trigger reloads the count, so a bouncing
	// trigger keeps the system in reset
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			hold_cnt <= RST_CNT_W'(RST_HOLD_CYCLES);
			// assert right away, no waiting on the count
			sys_rst_o <= 1'b1;
		end else begin
			// count down once trigger is gone
			if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			// registered, falls one cycle after count hits zero
			sys_rst_o <= (hold_cnt != '0);
		end
	end

	// reset stays up through the whole hold window
	assert property (@(posedge sys_clk)
		$fell(trigger_reset) |-> sys_rst_o [*RST_HOLD_CYCLES]);

endmodule

/* design/csr_bridge.sv */
// host request/response port to CSR bus sequencer with response hold
`timescale 1ns/1ps

module csr_bridge import csr_soc_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_i,

	// host request
	input  logic      req_valid_i,
	output logic      req_ready_o,
	input  csr_addr_t req_addr_i,
	input  logic      req_we_i,
	input  csr_data_t req_wdata_i,

	// host response
	output logic      rsp_valid_o,
	input  logic      rsp_ready_i,
	output csr_data_t rsp_rdata_o,

	// CSR bus master side
	output csr_addr_t csr_a_o,
	output logic      csr_we_o,
	output csr_data_t csr_dw_o,
	input  csr_data_t csr_dr_i
);

	// idle, drive bus, wait/hold response
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_RESP
	} state_t;

	state_t state_q;
	logic   accept;

	// handshake on the request side
	assign accept = req_valid_i & req_ready_o;

	// --------------------
	// sequencer
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state_q <= ST_IDLE;
			req_ready_o <= 1'b0;
			rsp_valid_o <= 1'b0;
			csr_we_o <= 1'b0;
		end else begin
			// write strobe is a single cycle pulse
			csr_we_o <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					req_ready_o <= 1'b1;
					if (accept) begin
						state_q <= ST_BUS;
						req_ready_o <= 1'b0;
						csr_we_o <= req_we_i;
					end
				end
				// slots act on the bus this cycle
				ST_BUS: begin
					state_q <= ST_RESP;
				end
				ST_RESP: begin
					// first cycle here the slot read data is settling
					if (!rsp_valid_o) begin
						rsp_valid_o <= 1'b1;
					end else if (rsp_ready_i) begin
						rsp_valid_o <= 1'b0;
						req_ready_o <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// bus and response data
	// --------------------
	always_ff @(posedge sys_clk) begin
		// latch request onto the CSR bus
		if (accept) begin
			csr_a_o <= req_addr_i;
			csr_dw_o <= req_wdata_i;
		end
		// sample merged read data, then hold it
		if (state_q == ST_RESP && !rsp_valid_o) begin
			rsp_rdata_o <= csr_dr_i;
		end
	end

	// no back-to-back write strobes
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_we_o |=> !csr_we_o);

	// response held until the host takes it
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o));

endmodule

/* design/timer_slot.sv */
// CSR timer peripheral: control, compare, count, pending flag and interrupt
`timescale 1ns/1ps

module timer_slot import csr_soc_pkg::*; #(
	parameter bank_t BANK = '0
) (
	input  logic      sys_clk,
	input  logic      sys_rst_i,

	// CSR bus
	input  csr_addr_t csr_a_i,
	input  logic      csr_we_i,
	input  csr_data_t csr_dw_i,
	output csr_data_t csr_do_o,

	output logic      irq_o
);

	// registers
	logic [CTRL_W-1:0] ctrl_q;
	csr_data_t         compare_q;
	csr_data_t         count_q;
	logic              pending_q;

	// decode
	logic       csr_sel;
	logic       csr_wr;
	logic [1:0] reg_ofs;
	logic       hit;

	// --------------------
	// address decode
	// --------------------
	// bank in the top bits, offset in the bottom two,
	// middle bits don't care
	assign csr_sel = (csr_a_i[CSR_ADDR_W-1 -: BANK_W] == BANK);
	assign reg_ofs = csr_a_i[1:0];
	assign csr_wr = csr_sel & csr_we_i;

	// compare match, only counts while running
	assign hit = ctrl_q[CTRL_EN_BIT] && (count_q == compare_q);

	// --------------------
	// counter and registers
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ctrl_q <= '0;
			compare_q <= '0;
			count_q <= '0;
			pending_q <= 1'b0;
		end else begin
			// free running up-count while enabled
			if (ctrl_q[CTRL_EN_BIT]) begin
				if (hit) begin
					pending_q <= 1'b1;
					if (ctrl_q[CTRL_RELOAD_BIT]) begin
						count_q <= '0;
					end else begin
						// one-shot, stop and keep count at compare
						ctrl_q[CTRL_EN_BIT] <= 1'b0;
					end
				end else begin
					count_q <= count_q + 1'b1;
				end
			end

			// write one to clear, a same-cycle match wins
			if (csr_wr && reg_ofs == REG_STATUS && csr_dw_i[0] && !hit) begin
				pending_q <= 1'b0;
			end

			// host writes override the counter update
			if (csr_wr) begin
				case (reg_ofs)
					REG_CTRL: ctrl_q <= csr_dw_i[CTRL_W-1:0];
					REG_COMPARE: compare_q <= csr_dw_i;
					REG_COUNT: count_q <= csr_dw_i;
					default: begin
					end
				endcase
			end
		end
	end

	// --------------------
	// read data
	// --------------------
	// zero when not addressed so the top can OR all slots
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_sel) begin
				case (reg_ofs)
					REG_CTRL: csr_do_o <= CSR_DATA_W'(ctrl_q);
					REG_COMPARE: csr_do_o <= compare_q;
					REG_COUNT: csr_do_o <= count_q;
					REG_STATUS: csr_do_o <= CSR_DATA_W'(pending_q);
					default: csr_do_o <= '0;
				endcase
			end
		end
	end

	// level interrupt, masked by irq-enable
	assign irq_o = pending_q & ctrl_q[CTRL_IRQEN_BIT];

	// pending only ever comes from a running counter
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		$rose(pending_q) |-> $past(ctrl_q[CTRL_EN_BIT]));

endmodule

/* design/csr_read_merge.sv */
// wired-OR of slot read data and registered interrupt vector
`timescale 1ns/1ps

module csr_read_merge import csr_soc_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,

	// per slot returns
	input  csr_data_t             slot_do_i [NUM_TIMERS],
	input  logic [NUM_TIMERS-1:0] slot_irq_i,

	// merged outputs
	output csr_data_t             csr_dr_o,
	output logic [NUM_TIMERS-1:0] irq_o
);

	// --------------------
	// read return
	// --------------------
	// unselected slots drive zero so OR is enough
	always_comb begin
		csr_dr_o = '0;
		for (int i = 0; i < NUM_TIMERS; i++) begin
			csr_dr_o = csr_dr_o | slot_do_i[i];
		end
	end

	// --------------------
	// interrupt vector
	// --------------------
	// bit i follows slot i after one flop stage
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			irq_o <= '0;
		end else begin
			irq_o <= slot_irq_i;
		end
	end

endmodule

/* design/csr_soc_top.sv */
// top level: reset stretcher, CSR bridge, timer row and read merge
`timescale 1ns/1ps

module csr_soc_top import csr_soc_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  trigger_reset,

	// host request
	input  logic                  req_valid_i,
	output logic                  req_ready_o,
	input  csr_addr_t             req_addr_i,
	input  logic                  req_we_i,
	input  csr_data_t             req_wdata_i,

	// host response
	output logic                  rsp_valid_o,
	input  logic                  rsp_ready_i,
	output csr_data_t             rsp_rdata_o,

	// one bit per timer bank
	output logic [NUM_TIMERS-1:0] irq_o
);

	// --------------------
	// wires
	// --------------------
	logic                  sys_rst;
	// shared CSR bus
	csr_addr_t             csr_a;
	logic                  csr_we;
	csr_data_t             csr_dw;
	csr_data_t             csr_dr;
	// per slot returns
	csr_data_t             slot_do [NUM_TIMERS];
	logic [NUM_TIMERS-1:0] slot_irq;

	// held system reset
	reset_debounce rst_gen (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.sys_rst_o(sys_rst)
	);

	// host port to CSR bus
	csr_bridge csrbrg (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.req_valid_i(req_valid_i),
		.req_ready_o(req_ready_o),
		.req_addr_i(req_addr_i),
		.req_we_i(req_we_i),
		.req_wdata_i(req_wdata_i),
		.rsp_valid_o(rsp_valid_o),
		.rsp_ready_i(rsp_ready_i),
		.rsp_rdata_o(rsp_rdata_o),
		.csr_a_o(csr_a),
		.csr_we_o(csr_we),
		.csr_dw_o(csr_dw),
		.csr_dr_i(csr_dr)
	);

	// timer row, bank number = index
	for (genvar g = 0; g < NUM_TIMERS; g++) begin : g_timer
		timer_slot #(
			.BANK(bank_t'(g))
		) timer (
			.sys_clk(sys_clk),
			.sys_rst_i(sys_rst),
			.csr_a_i(csr_a),
			.csr_we_i(csr_we),
			.csr_dw_i(csr_dw),
			.csr_do_o(slot_do[g]),
			.irq_o(slot_irq[g])
		);
	end

	// read-data OR and irq collection
	csr_read_merge merge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.slot_do_i(slot_do),
		.slot_irq_i(slot_irq),
		.csr_dr_o(csr_dr),
		.irq_o(irq_o)
	);

endmodule

/* bench/tb_csr_soc.sv */
// testbench for the CSR timer subsystem: clock, reset, directed tests, checks and timeout
`timescale 1ns/1ps

module tb_csr_soc import csr_soc_pkg::*; ();

	// tests take about 500 cycles, wide margin on top
	localparam int TIMEOUT_CYCLES = 4000;
	// status polls before a timer counts as dead
	localparam int POLL_LIMIT = 20;

	logic                  sys_clk;
	logic                  trigger_reset;
	logic                  req_valid_i;
	logic                  req_ready_o;
	csr_addr_t             req_addr_i;
	logic                  req_we_i;
	csr_data_t             req_wdata_i;
	logic                  rsp_valid_o;
	logic                  rsp_ready_i;
	csr_data_t             rsp_rdata_o;
	logic [NUM_TIMERS-1:0] irq_o;

	integer    seed;
	int        cycle_cnt;
	// compare values written per bank
	csr_data_t cmp_val [NUM_TIMERS];

	csr_soc_top dut0 (.*);

	// 20 ns period
	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// watchdog, counts every rising edge
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("ERROR at %0t: run hung, no finish after %0d cycles", $time, TIMEOUT_CYCLES);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// --------------------
	// checks
	// --------------------
	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got %h, expected %h)",
				$time, msg, actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	task automatic abort_run(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "stopping run");
	endtask

	// --------------------
	// host port access
	// --------------------
	// bank on top, offset at the bottom, middle bits left zero
	function automatic csr_addr_t make_addr(input int bank, input logic [1:0] ofs);
		csr_addr_t a;
		a = '0;
		a[CSR_ADDR_W-1 -: BANK_W] = bank_t'(bank);
		a[1:0] = ofs;
		return a;
	endfunction

	// starts and ends just after a falling edge
	task automatic bus_access(input logic we, input csr_addr_t addr, input csr_data_t wdata,
			output csr_data_t rdata);
		req_valid_i = 1'b1;
		req_addr_i = addr;
		req_we_i = we;
		req_wdata_i = wdata;
		rsp_ready_i = 1'b1;
		while (!req_ready_o) @(negedge sys_clk);
		// accepted on the rising edge in between
		@(negedge sys_clk);
		req_valid_i = 1'b0;
		while (!rsp_valid_o) @(negedge sys_clk);
		rdata = rsp_rdata_o;
		// response taken on the next rising edge
		@(negedge sys_clk);
	endtask

	task automatic csr_write(input int bank, input logic [1:0] ofs, input csr_data_t data);
		csr_data_t unused;
		bus_access(1'b1, make_addr(bank, ofs), data, unused);
	endtask

	task automatic csr_read(input int bank, input logic [1:0] ofs, output csr_data_t data);
		bus_access(1'b0, make_addr(bank, ofs), '0, data);
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic test_reset();
		csr_data_t rd;
		int        waited;
		// first two cycles let the reset reach the flops
		repeat (2) @(negedge sys_clk);
		repeat (2) begin
			@(negedge sys_clk);
			check_eq(req_ready_o, 1'b0, "req_ready_o low during reset");
			check_eq(rsp_valid_o, 1'b0, "rsp_valid_o low during reset");
			check_eq(irq_o, '0, "irq_o low during reset");
		end
		trigger_reset = 1'b0;
		@(negedge sys_clk);
		check_eq(req_ready_o, 1'b0, "req_ready_o low right after trigger falls");
		check_eq(rsp_valid_o, 1'b0, "rsp_valid_o low right after trigger falls");
		check_eq(irq_o, '0, "irq_o low right after trigger falls");
		waited = 0;
		while (!req_ready_o && waited < RST_HOLD_CYCLES + 4) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!req_ready_o) abort_run("req_ready_o never rose after reset was released");
		// whole register file starts cleared
		for (int b = 0; b < NUM_TIMERS; b++) begin
			for (int r = 0; r < 4; r++) begin
				csr_read(b, 2'(r), rd);
				check_eq(rd, '0, $sformatf("bank %0d reg %0d zero after reset", b, r));
			end
		end
	endtask

	task automatic test_readback();
		csr_data_t rd;
		for (int b = 0; b < NUM_TIMERS; b++) begin
			cmp_val[b] = $random(seed);
			csr_write(b, REG_COMPARE, cmp_val[b]);
		end
		// all writes first, so shared storage would show up
		for (int b = 0; b < NUM_TIMERS; b++) begin
			csr_read(b, REG_COMPARE, rd);
			check_eq(rd, cmp_val[b], $sformatf("bank %0d compare readback", b));
		end
		csr_write(9, REG_COMPARE, 32'hffff_ffff);
		csr_read(9, REG_COMPARE, rd);
		check_eq(rd, '0, "unmapped bank 9 reads zero");
	endtask

	task automatic test_latency();
		csr_data_t held;
		int        lat;
		rsp_ready_i = 1'b0;
		req_valid_i = 1'b1;
		req_addr_i = make_addr(0, REG_COMPARE);
		req_we_i = 1'b0;
		while (!req_ready_o) @(negedge sys_clk);
		@(negedge sys_clk);
		req_valid_i = 1'b0;
		// edges seen since the accepting edge
		lat = 0;
		while (!rsp_valid_o && lat < 10) begin
			check_eq(req_ready_o, 1'b0, "req_ready_o low while busy");
			@(negedge sys_clk);
			lat++;
		end
		check_eq(lat, 2, "read latency from acceptance to rsp_valid_o");
		held = rsp_rdata_o;
		check_eq(held, cmp_val[0], "read data under back-pressure");
		repeat (5) begin
			@(negedge sys_clk);
			check_eq(rsp_valid_o, 1'b1, "rsp_valid_o held under back-pressure");
			check_eq(rsp_rdata_o, held, "rsp_rdata_o stable under back-pressure");
			check_eq(req_ready_o, 1'b0, "req_ready_o low under back-pressure");
		end
		rsp_ready_i = 1'b1;
		@(negedge sys_clk);
		check_eq(rsp_valid_o, 1'b0, "rsp_valid_o drops after transfer");
	endtask

	task automatic test_oneshot(input int bank);
		csr_data_t rd;
		int        polls;
		csr_write(bank, REG_COMPARE, 32'd20);
		csr_write(bank, REG_COUNT, '0);
		csr_write(bank, REG_CTRL, (1 << CTRL_EN_BIT) | (1 << CTRL_IRQEN_BIT));
		rd = '0;
		polls = 0;
		while (rd[0] !== 1'b1 && polls < POLL_LIMIT) begin
			csr_read(bank, REG_STATUS, rd);
			polls++;
		end
		if (rd[0] !== 1'b1) abort_run("one-shot timer never set its pending bit");
		check_eq(irq_o, 1 << bank, "only the one-shot bank raises irq");
		csr_read(bank, REG_CTRL, rd);
		check_eq(rd[CTRL_EN_BIT], 1'b0, "one-shot clears its enable bit");
		csr_read(bank, REG_COUNT, rd);
		check_eq(rd, 32'd20, "one-shot count holds at compare");
		// write one to clear
		csr_write(bank, REG_STATUS, 32'd1);
		check_eq(irq_o, '0, "irq_o falls after pending is cleared");
		csr_read(bank, REG_STATUS, rd);
		check_eq(rd, '0, "pending cleared");
		csr_write(bank, REG_CTRL, '0);
	endtask

	task automatic test_autoreload(input int bank);
		csr_data_t rd;
		int        polls;
		csr_write(bank, REG_COMPARE, 32'd10);
		csr_write(bank, REG_COUNT, '0);
		csr_write(bank, REG_CTRL, (1 << CTRL_EN_BIT) | (1 << CTRL_RELOAD_BIT));
		rd = '0;
		polls = 0;
		while (rd[0] !== 1'b1 && polls < POLL_LIMIT) begin
			csr_read(bank, REG_STATUS, rd);
			check_eq(irq_o, '0, "irq_o stays low with irq-enable off");
			polls++;
		end
		if (rd[0] !== 1'b1) abort_run("auto-reload timer never set its pending bit");
		csr_read(bank, REG_CTRL, rd);
		check_eq(rd[CTRL_EN_BIT], 1'b1, "auto-reload keeps its enable bit");
		// wraps at compare, never beyond
		repeat (8) begin
			csr_read(bank, REG_COUNT, rd);
			check_eq(rd <= 32'd10, 1'b1, $sformatf("count %0d within compare", rd));
			check_eq(irq_o, '0, "irq_o still low while reloading");
		end
		csr_write(bank, REG_CTRL, '0);
		csr_write(bank, REG_STATUS, 32'd1);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		seed = 32'ha8db;
		trigger_reset = 1'b1;
		req_valid_i = 1'b0;
		req_addr_i = '0;
		req_we_i = 1'b0;
		req_wdata_i = '0;
		rsp_ready_i = 1'b1;
		test_reset();
		test_readback();
		test_latency();
		test_oneshot(2);
		test_autoreload(1);
		$display("Simulation passed");
		$finish;
	end

endmodule

/* vlog.f */
design/csr_soc_pkg.sv
design/reset_debounce.sv
design/csr_bridge.sv
design/timer_slot.sv
design/csr_read_merge.sv
design/csr_soc_top.sv
bench/tb_csr_soc.sv

/* Bender.yml */
package:
  name: csr_soc

sources:
  - design/csr_soc_pkg.sv
  - design/reset_debounce.sv
  - design/csr_bridge.sv
  - design/timer_slot.sv
  - design/csr_read_merge.sv
  - design/csr_soc_top.sv
  - target: simulation
    files:
      - bench/tb_csr_soc.sv
